/* llc_pkg.sv */
package llc_pkg;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  rem_t;
   typedef logic [2:0]  flag_t;
   typedef logic [31:0] len_t;
   typedef logic [9:0]  task_t;

   // Job header layout
   localparam int HDR_WORDS = 8;
   localparam int FLAG_WORD = 4;
   localparam int LEN_WORD  = 5;
   localparam int TASK_WORD = 6;

   // A set bit in a remainder code marks an unused lane
   localparam rem_t REM_4B = 4'b0000;
   localparam rem_t REM_3B = 4'b0001;
   localparam rem_t REM_2B = 4'b0011;
   localparam rem_t REM_1B = 4'b0111;

   localparam word_t CRC_POLY = 32'h04C1_1DB7;
   localparam word_t CRC_INIT = 32'hFFFF_FFFF;

   // Valid bytes in a word
   function automatic logic [2:0] rem_bytes(input rem_t r);
      case (r)
         REM_3B:  return 3'd3;
         REM_2B:  return 3'd2;
         REM_1B:  return 3'd1;
         default: return 3'd4;
      endcase
   endfunction

   function automatic word_t rem_mask(input word_t d, input rem_t r);
      case (r)
         REM_3B:  return {d[31:8], 8'h00};
         REM_2B:  return {d[31:16], 16'h0000};
         REM_1B:  return {d[31:24], 24'h00_0000};
         default: return d;
      endcase
   endfunction

   // One MSB-first CRC-32 step over a full word
   function automatic word_t crc_step(input word_t c, input word_t d);
      word_t n;
      n = c;
      for (int i = 31; i >= 0; i--) begin
         if (n[31] ^ d[i]) begin
            n = {n[30:0], 1'b0} ^ CRC_POLY;
         end else begin
            n = {n[30:0], 1'b0};
         end
      end
      return n;
   endfunction

endpackage

/* llc_ifs.sv */
`timescale 1ns/10ps

// Payload words from decoder to engine
interface llc_pay_if;
   logic           wr;
   llc_pkg::word_t data;
   llc_pkg::rem_t  rem;
   logic           last;
   logic           room;

   modport source (output wr, data, rem, last, input room);
   modport sink   (input wr, data, rem, last, output room);
endinterface

// Job fields from decoder to builder
interface llc_job_if;
   logic           start;
   llc_pkg::flag_t flags;
   llc_pkg::len_t  len;
   llc_pkg::task_t task_idx;
   logic           done;

   modport source (output start, flags, len, task_idx, input done);
   modport sink   (input start, flags, len, task_idx, output done);
endinterface

// Buffered payload and totals from engine to builder
interface llc_drain_if;
   llc_pkg::word_t data;
   llc_pkg::rem_t  rem;
   logic           last;
   logic           avail;
   llc_pkg::len_t  byte_cnt;
   llc_pkg::word_t crc;
   logic           pop;

   modport source (output data, rem, last, avail, byte_cnt, crc, input pop);
   modport sink   (input data, rem, last, avail, byte_cnt, crc, output pop);
endinterface

/* llc_header_decoder.sv */
`timescale 1ns/10ps

module llc_header_decoder (
   input  logic           clk,
   input  logic           rst_n,
   input  llc_pkg::word_t tx_d_i,
   input  llc_pkg::rem_t  tx_rem_i,
   input  logic           tx_sof_n_i,
   input  logic           tx_sop_n_i,
   input  logic           tx_eop_n_i,
   input  logic           tx_eof_n_i,
   input  logic           tx_src_rdy_n_i,
   output logic           tx_dst_rdy_n_o,
   llc_pay_if.source      pay,
   llc_job_if.source      job
);

   localparam int CW = $clog2(llc_pkg::HDR_WORDS);

   typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD, WAIT_DONE} state_t;

   state_t        state;
   logic [CW-1:0] hdr_cnt;
   logic          armed;
   logic          accept;
   logic          early_pay;

   assign tx_dst_rdy_n_o = !(armed && pay.room && state != WAIT_DONE);
   assign accept = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;

   // Start-of-payload inside the header cuts it short
   assign early_pay = (state == HEADER) && !tx_sop_n_i;

   assign pay.wr   = accept && (state == PAYLOAD || early_pay);
   assign pay.data = tx_d_i;
   assign pay.rem  = tx_rem_i;
   assign pay.last = !tx_eop_n_i || !tx_eof_n_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= IDLE;
         hdr_cnt   <= '0;
         armed     <= 1'b0;
         job.start <= 1'b0;
      end else begin
         armed     <= 1'b1;
         job.start <= 1'b0;
         if (accept) begin
            case (state)
               IDLE: begin
                  if (!tx_sof_n_i) begin
                     state   <= HEADER;
                     hdr_cnt <= CW'(1);
                  end
               end
               HEADER: begin
                  if (early_pay) begin
                     job.start <= (hdr_cnt <= CW'(llc_pkg::TASK_WORD));
                     state     <= pay.last ? WAIT_DONE : PAYLOAD;
                  end else begin
                     hdr_cnt   <= hdr_cnt + CW'(1);
                     job.start <= (hdr_cnt == CW'(llc_pkg::TASK_WORD));
                     if (hdr_cnt == CW'(llc_pkg::HDR_WORDS - 1)) begin
                        state <= PAYLOAD;
                     end
                  end
               end
               PAYLOAD: begin
                  if (pay.last) begin
                     state <= WAIT_DONE;
                  end
               end
               default: ;
            endcase
         end
         if (state == WAIT_DONE && job.done) begin
            state <= IDLE;
         end
      end
   end

   // Header fields
   always_ff @(posedge clk) begin
      if (accept && state == HEADER && tx_sop_n_i) begin
         if (hdr_cnt == CW'(llc_pkg::FLAG_WORD)) begin
            job.flags <= tx_d_i[31:29];
         end
         if (hdr_cnt == CW'(llc_pkg::LEN_WORD)) begin
            job.len <= tx_d_i;
         end
         if (hdr_cnt == CW'(llc_pkg::TASK_WORD)) begin
            job.task_idx <= tx_d_i[9:0];
         end
      end
   end

endmodule

/* llc_payload_engine.sv */
`timescale 1ns/10ps

module llc_payload_engine #(
   parameter int FIFO_DEPTH = 8
) (
   input logic         clk,
   input logic         rst_n,
   llc_pay_if.sink     pay,
   llc_drain_if.source drain
);

   localparam int AW = $clog2(FIFO_DEPTH);

   llc_pkg::word_t        mem_data [FIFO_DEPTH];
   llc_pkg::rem_t         mem_rem  [FIFO_DEPTH];
   logic [FIFO_DEPTH-1:0] mem_last;
   logic [AW:0]           wr_ptr;
   logic [AW:0]           rd_ptr;
   llc_pkg::rem_t         eff_rem;
   llc_pkg::word_t        masked;
   llc_pkg::len_t         byte_cnt;
   llc_pkg::word_t        crc;
   logic                  restart;

   // Remainder only counts on the last word
   assign eff_rem = pay.last ? pay.rem : llc_pkg::REM_4B;
   assign masked  = llc_pkg::rem_mask(pay.data, eff_rem);

   // Extra pointer bit tells full from empty
   assign pay.room    = !((wr_ptr[AW] != rd_ptr[AW]) &&
                          (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]));
   assign drain.avail = (wr_ptr != rd_ptr);

   assign drain.data     = mem_data[rd_ptr[AW-1:0]];
   assign drain.rem      = mem_rem[rd_ptr[AW-1:0]];
   assign drain.last     = mem_last[rd_ptr[AW-1:0]];
   assign drain.byte_cnt = byte_cnt;
   assign drain.crc      = crc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (pay.wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (drain.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pay.wr) begin
         mem_data[wr_ptr[AW-1:0]] <= masked;
         mem_rem[wr_ptr[AW-1:0]]  <= eff_rem;
         mem_last[wr_ptr[AW-1:0]] <= pay.last;
      end
   end

   // Frame totals held until the next frame begins
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         restart <= 1'b1;
      end else if (pay.wr) begin
         restart <= pay.last;
      end
   end

   always_ff @(posedge clk) begin
      if (pay.wr) begin
         byte_cnt <= (restart ? '0 : byte_cnt) +
                     llc_pkg::len_t'(llc_pkg::rem_bytes(eff_rem));
         crc      <= llc_pkg::crc_step(restart ? llc_pkg::CRC_INIT : crc, masked);
      end
   end

endmodule

/* llc_completion_builder.sv */
`timescale 1ns/10ps

module llc_completion_builder (
   input  logic           clk,
   input  logic           rst_n,
   llc_drain_if.sink      drain,
   llc_job_if.sink        job,
   output llc_pkg::word_t rx_d_o,
   output llc_pkg::rem_t  rx_rem_o,
   output logic           rx_sof_n_o,
   output logic           rx_sop_n_o,
   output logic           rx_eop_n_o,
   output logic           rx_eof_n_o,
   output logic           rx_src_rdy_n_o,
   input  logic           rx_dst_rdy_n_i
);

   typedef enum logic [2:0] {IDLE, PAYLOAD, STATUS, LENGTH, TASK, CRC} state_t;

   state_t         state;
   state_t         state_d;
   logic           first;
   logic           taken;
   logic           can_load;
   logic           load;
   llc_pkg::word_t ld_data;
   llc_pkg::rem_t  ld_rem;
   logic           ld_first;
   logic           ld_eop;
   logic           ld_eof;
   logic           match;

   assign taken    = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;
   assign can_load = rx_src_rdy_n_o || taken;
   assign match    = (drain.byte_cnt == job.len);

   always_comb begin
      state_d  = state;
      load     = 1'b0;
      ld_data  = '0;
      ld_rem   = llc_pkg::REM_4B;
      ld_first = 1'b0;
      ld_eop   = 1'b0;
      ld_eof   = 1'b0;
      case (state)
         IDLE: begin
            if (job.start) begin
               state_d = PAYLOAD;
            end
         end
         PAYLOAD: begin
            if (can_load && drain.avail) begin
               load     = 1'b1;
               ld_data  = drain.data;
               ld_rem   = drain.rem;
               ld_first = first;
               ld_eop   = drain.last;
               if (drain.last) begin
                  state_d = STATUS;
               end
            end
         end
         STATUS: begin
            load    = can_load;
            ld_data = {job.flags, match, 28'd0};
            state_d = can_load ? LENGTH : STATUS;
         end
         LENGTH: begin
            load    = can_load;
            ld_data = drain.byte_cnt;
            state_d = can_load ? TASK : LENGTH;
         end
         TASK: begin
            load    = can_load;
            ld_data = {22'd0, job.task_idx};
            state_d = can_load ? CRC : TASK;
         end
         CRC: begin
            load    = can_load;
            ld_data = drain.crc;
            ld_eof  = 1'b1;
            state_d = can_load ? IDLE : CRC;
         end
         default: state_d = IDLE;
      endcase
   end

   assign drain.pop = load && (state == PAYLOAD);
   assign job.done  = taken && !rx_eof_n_o;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state          <= IDLE;
         first          <= 1'b0;
         rx_src_rdy_n_o <= 1'b1;
         rx_sof_n_o     <= 1'b1;
         rx_sop_n_o     <= 1'b1;
         rx_eop_n_o     <= 1'b1;
         rx_eof_n_o     <= 1'b1;
      end else begin
         state <= state_d;
         if (job.start) begin
            first <= 1'b1;
         end else if (drain.pop) begin
            first <= 1'b0;
         end
         if (load) begin
            rx_src_rdy_n_o <= 1'b0;
            rx_sof_n_o     <= !ld_first;
            rx_sop_n_o     <= !ld_first;
            rx_eop_n_o     <= !ld_eop;
            rx_eof_n_o     <= !ld_eof;
         end else if (taken) begin
            // Drop framing once the word is gone with nothing new
            rx_src_rdy_n_o <= 1'b1;
            rx_sof_n_o     <= 1'b1;
            rx_sop_n_o     <= 1'b1;
            rx_eop_n_o     <= 1'b1;
            rx_eof_n_o     <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         rx_d_o   <= ld_data;
         rx_rem_o <= ld_rem;
      end
   end

endmodule

/* llc_copy_unit.sv */
`timescale 1ns/10ps

module llc_copy_unit #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic           clk,
   input  logic           rst_n,
   input  llc_pkg::word_t tx_d_i,
   input  llc_pkg::rem_t  tx_rem_i,
   input  logic           tx_sof_n_i,
   input  logic           tx_eof_n_i,
   input  logic           tx_sop_n_i,
   input  logic           tx_eop_n_i,
   input  logic           tx_src_rdy_n_i,
   output logic           tx_dst_rdy_n_o,
   output llc_pkg::word_t rx_d_o,
   output llc_pkg::rem_t  rx_rem_o,
   output logic           rx_sof_n_o,
   output logic           rx_eof_n_o,
   output logic           rx_sop_n_o,
   output logic           rx_eop_n_o,
   output logic           rx_src_rdy_n_o,
   input  logic           rx_dst_rdy_n_i
);

   llc_pay_if   pay_if ();
   llc_job_if   job_if ();
   llc_drain_if drain_if ();

   llc_header_decoder u_decode (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d_i),
      .tx_rem_i       (tx_rem_i),
      .tx_sof_n_i     (tx_sof_n_i),
      .tx_sop_n_i     (tx_sop_n_i),
      .tx_eop_n_i     (tx_eop_n_i),
      .tx_eof_n_i     (tx_eof_n_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .pay            (pay_if),
      .job            (job_if)
   );

   llc_payload_engine #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_execute (
      .clk   (clk),
      .rst_n (rst_n),
      .pay   (pay_if),
      .drain (drain_if)
   );

   llc_completion_builder u_result (
      .clk            (clk),
      .rst_n          (rst_n),
      .drain          (drain_if),
      .job            (job_if),
      .rx_d_o         (rx_d_o),
      .rx_rem_o       (rx_rem_o),
      .rx_sof_n_o     (rx_sof_n_o),
      .rx_sop_n_o     (rx_sop_n_o),
      .rx_eop_n_o     (rx_eop_n_o),
      .rx_eof_n_o     (rx_eof_n_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
   );

endmodule

/* llc_copy_unit_props.sv */
`timescale 1ns/10ps

module llc_copy_unit_props (
   input logic           clk,
   input logic           rst_n,
   input llc_pkg::word_t rx_d_i,
   input llc_pkg::rem_t  rx_rem_i,
   input logic           rx_sof_n_i,
   input logic           rx_sop_n_i,
   input logic           rx_eop_n_i,
   input logic           rx_eof_n_i,
   input logic           rx_src_rdy_n_i,
   input logic           rx_dst_rdy_n_i
);

   int unsigned fail_cnt = 0;

   eof_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !rx_eof_n_i |-> !rx_src_rdy_n_i)
      else begin
         $error("Receive end-of-frame without source-ready");
         fail_cnt++;
      end

   // Stalled word holds data and framing
   hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n_i && rx_dst_rdy_n_i) |=>
         (!rx_src_rdy_n_i && $stable(rx_d_i) && $stable(rx_rem_i) &&
          $stable({rx_sof_n_i, rx_sop_n_i, rx_eop_n_i, rx_eof_n_i})))
      else begin
         $error("Receive word changed while stalled");
         fail_cnt++;
      end

   sof_with_sop: assert property (@(posedge clk) disable iff (!rst_n)
      !rx_sof_n_i |-> !rx_sop_n_i)
      else begin
         $error("Receive start-of-frame without start-of-payload");
         fail_cnt++;
      end

endmodule

bind llc_copy_unit llc_copy_unit_props u_props (
   .clk            (clk),
   .rst_n          (rst_n),
   .rx_d_i         (rx_d_o),
   .rx_rem_i       (rx_rem_o),
   .rx_sof_n_i     (rx_sof_n_o),
   .rx_sop_n_i     (rx_sop_n_o),
   .rx_eop_n_i     (rx_eop_n_o),
   .rx_eof_n_i     (rx_eof_n_o),
   .rx_src_rdy_n_i (rx_src_rdy_n_o),
   .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
);

/* tb_llc_copy_unit.sv */
`timescale 1ns/10ps

module tb_llc_copy_unit;

   localparam int FIFO_DEPTH = 8;
   localparam int N_FRAMES   = 8;
   localparam int TIMEOUT    = 200;

   logic           clk;
   logic           rst_n;
   llc_pkg::word_t tx_d_i;
   llc_pkg::rem_t  tx_rem_i;
   logic           tx_sof_n_i, tx_eof_n_i, tx_sop_n_i, tx_eop_n_i, tx_src_rdy_n_i;
   logic           tx_dst_rdy_n_o;
   llc_pkg::word_t rx_d_o;
   llc_pkg::rem_t  rx_rem_o;
   logic           rx_sof_n_o, rx_eof_n_o, rx_sop_n_o, rx_eop_n_o, rx_src_rdy_n_o;
   logic           rx_dst_rdy_n_i;

   // Frame table
   llc_pkg::flag_t tbl_flags [N_FRAMES];
   llc_pkg::len_t  tbl_len   [N_FRAMES];
   llc_pkg::task_t tbl_task  [N_FRAMES];
   int             tbl_words [N_FRAMES];
   llc_pkg::rem_t  tbl_rem   [N_FRAMES];
   logic           tbl_stall [N_FRAMES];
   int             n_tbl = 0;

   llc_pkg::word_t tx_q[$];
   llc_pkg::word_t exp_d[$];
   llc_pkg::rem_t  exp_rem[$];
   logic [3:0]     exp_frm[$];
   logic [31:0]    lfsr = 32'hefdb;
   int             val_errs = 0;
   int             other_errs = 0;
   int             cur_frame = 0;
   int             cur_word = 0;

   llc_copy_unit #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic random_bits(input int n, output llc_pkg::word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic int lane_count(input llc_pkg::rem_t r);
      if (r == llc_pkg::REM_3B) return 3;
      if (r == llc_pkg::REM_2B) return 2;
      if (r == llc_pkg::REM_1B) return 1;
      return 4;
   endfunction

   // Lane 0 is the most significant byte
   function automatic llc_pkg::word_t keep_lanes(input llc_pkg::word_t w, input int nb);
      llc_pkg::word_t m;
      m = w;
      for (int j = 0; j < 4; j++) begin
         if (j >= nb) m[31-8*j -: 8] = 8'h00;
      end
      return m;
   endfunction

   task automatic check_word(input string name, input llc_pkg::word_t got,
                             input llc_pkg::word_t exp);
      if (got !== exp) begin
         $display("FAILED %s got %h expected %h (frame %0d word %0d)",
                  name, got, exp, cur_frame, cur_word);
         val_errs++;
      end
   endtask

   task automatic check_rem(input string name, input llc_pkg::rem_t got,
                            input llc_pkg::rem_t exp);
      if (got !== exp) begin
         $display("FAILED %s got %h expected %h (frame %0d word %0d)",
                  name, got, exp, cur_frame, cur_word);
         val_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s got %h expected %h (frame %0d word %0d)",
                  name, got, exp, cur_frame, cur_word);
         val_errs++;
      end
   endtask

   task automatic add_frame(input llc_pkg::flag_t fl, input llc_pkg::len_t len,
                            input llc_pkg::task_t tk, input int nw,
                            input llc_pkg::rem_t r, input logic st);
      tbl_flags[n_tbl] = fl;
      tbl_len[n_tbl]   = len;
      tbl_task[n_tbl]  = tk;
      tbl_words[n_tbl] = nw;
      tbl_rem[n_tbl]   = r;
      tbl_stall[n_tbl] = st;
      n_tbl++;
   endtask

   // Transmit words and expected receive frame
   task automatic prepare_frame(input int f);
      llc_pkg::word_t w;
      llc_pkg::word_t crc;
      llc_pkg::len_t  cnt;
      logic           last;
      logic           fb;
      int             nb;
      tx_q.delete();
      exp_d.delete();
      exp_rem.delete();
      exp_frm.delete();
      for (int k = 0; k < llc_pkg::HDR_WORDS; k++) begin
         random_bits(32, w);
         if (k == llc_pkg::FLAG_WORD) w[31:29] = tbl_flags[f];
         if (k == llc_pkg::LEN_WORD) w = tbl_len[f];
         if (k == llc_pkg::TASK_WORD) w[9:0] = tbl_task[f];
         tx_q.push_back(w);
      end
      crc = llc_pkg::CRC_INIT;
      cnt = '0;
      for (int k = 0; k < tbl_words[f]; k++) begin
         random_bits(32, w);
         tx_q.push_back(w);
         last = (k == tbl_words[f] - 1);
         nb = last ? lane_count(tbl_rem[f]) : 4;
         w = keep_lanes(w, nb);
         cnt += nb;
         for (int b = 31; b >= 0; b--) begin
            fb  = crc[31] ^ w[b];
            crc = {crc[30:0], 1'b0};
            if (fb) crc = crc ^ llc_pkg::CRC_POLY;
         end
         exp_d.push_back(w);
         exp_rem.push_back(last ? tbl_rem[f] : llc_pkg::REM_4B);
         exp_frm.push_back({k == 0, k == 0, last, 1'b0});
      end
      // Trailer words with framing packed as {sof, sop, eop, eof}
      exp_d.push_back({tbl_flags[f], cnt == tbl_len[f], 28'd0});
      exp_d.push_back(cnt);
      exp_d.push_back({22'd0, tbl_task[f]});
      exp_d.push_back(crc);
      for (int k = 0; k < 4; k++) begin
         exp_rem.push_back(llc_pkg::REM_4B);
         exp_frm.push_back({3'b000, k == 3});
      end
   endtask

   task automatic send_frame(input int f);
      int   wait_cnt;
      logic last;
      for (int k = 0; k < tx_q.size(); k++) begin
         last = (k == tx_q.size() - 1);
         @(posedge clk);
         #1;
         tx_d_i         = tx_q[k];
         tx_rem_i       = last ? tbl_rem[f] : llc_pkg::REM_4B;
         tx_sof_n_i     = (k != 0);
         tx_sop_n_i     = (k != llc_pkg::HDR_WORDS);
         tx_eop_n_i     = !last;
         tx_eof_n_i     = !last;
         tx_src_rdy_n_i = 1'b0;
         wait_cnt = 0;
         @(negedge clk);
         while (tx_dst_rdy_n_o && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
         end
         if (tx_dst_rdy_n_o) begin
            $display("Timeout: transmit word %0d of frame %0d was never accepted", k, f);
            other_errs++;
            break;
         end
      end
      @(posedge clk);
      #1;
      tx_src_rdy_n_i = 1'b1;
      tx_sof_n_i     = 1'b1;
      tx_sop_n_i     = 1'b1;
      tx_eop_n_i     = 1'b1;
      tx_eof_n_i     = 1'b1;
   endtask

   task automatic receive_frame(input int f);
      llc_pkg::word_t b;
      int             idx;
      int             idle;
      idx  = 0;
      idle = 0;
      while (idx < exp_d.size()) begin
         @(posedge clk);
         #1;
         if (tbl_stall[f]) begin
            random_bits(1, b);
            rx_dst_rdy_n_i = b[0];
         end else begin
            rx_dst_rdy_n_i = 1'b0;
         end
         @(negedge clk);
         if (!rx_src_rdy_n_o && !rx_dst_rdy_n_i) begin
            cur_word = idx;
            check_word("rx_d_o", rx_d_o, exp_d[idx]);
            check_rem("rx_rem_o", rx_rem_o, exp_rem[idx]);
            check_flag("rx_sof_n_o", rx_sof_n_o, !exp_frm[idx][3]);
            check_flag("rx_sop_n_o", rx_sop_n_o, !exp_frm[idx][2]);
            check_flag("rx_eop_n_o", rx_eop_n_o, !exp_frm[idx][1]);
            check_flag("rx_eof_n_o", rx_eof_n_o, !exp_frm[idx][0]);
            idx++;
            idle = 0;
         end else begin
            idle++;
            if (idle > TIMEOUT) begin
               $display("Timeout: receive word %0d of frame %0d never arrived", idx, f);
               other_errs++;
               break;
            end
         end
      end
   endtask

   initial begin
      int wait_cnt;
      tx_d_i         = '0;
      tx_rem_i       = llc_pkg::REM_4B;
      tx_sof_n_i     = 1'b1;
      tx_eof_n_i     = 1'b1;
      tx_sop_n_i     = 1'b1;
      tx_eop_n_i     = 1'b1;
      tx_src_rdy_n_i = 1'b1;
      rx_dst_rdy_n_i = 1'b1;
      rst_n          = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("tx_dst_rdy_n_o", tx_dst_rdy_n_o, 1'b1);
      check_flag("rx_src_rdy_n_o", rx_src_rdy_n_o, 1'b1);
      check_flag("rx_sof_n_o", rx_sof_n_o, 1'b1);
      check_flag("rx_sop_n_o", rx_sop_n_o, 1'b1);
      check_flag("rx_eop_n_o", rx_eop_n_o, 1'b1);
      check_flag("rx_eof_n_o", rx_eof_n_o, 1'b1);
      wait_cnt = 0;
      while (tx_dst_rdy_n_o && wait_cnt < 10) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (tx_dst_rdy_n_o) begin
         $display("Timeout: transmit side never became ready after reset");
         other_errs++;
      end

      add_frame(3'b101, 32'd16,  10'h155, 4,  llc_pkg::REM_4B, 1'b0);
      add_frame(3'b010, 32'd11,  10'h003, 3,  llc_pkg::REM_3B, 1'b0);
      add_frame(3'b111, 32'd18,  10'h3ff, 5,  llc_pkg::REM_2B, 1'b1);
      add_frame(3'b001, 32'd100, 10'h200, 2,  llc_pkg::REM_1B, 1'b0);
      add_frame(3'b000, 32'd1,   10'h000, 1,  llc_pkg::REM_1B, 1'b1);
      add_frame(3'b110, 32'd80,  10'h0f0, 20, llc_pkg::REM_4B, 1'b1);
      add_frame(3'b011, 32'd51,  10'h0a5, 13, llc_pkg::REM_3B, 1'b1);
      // Unknown remainder code counts as four bytes
      add_frame(3'b100, 32'd35,  10'h2aa, 9,  4'b1111,         1'b1);

      for (int f = 0; f < n_tbl && other_errs == 0; f++) begin
         cur_frame = f;
         prepare_frame(f);
         fork
            send_frame(f);
            receive_frame(f);
         join
      end

      repeat (4) @(posedge clk);
      #1;
      other_errs += DUT.u_props.fail_cnt;
      $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* sources.f */
llc_pkg.sv
llc_ifs.sv
llc_header_decoder.sv
llc_payload_engine.sv
llc_completion_builder.sv
llc_copy_unit.sv
llc_copy_unit_props.sv
tb_llc_copy_unit.sv

/* Bender.yml */
package:
  name: llc_copy_unit

sources:
  - llc_pkg.sv
  - llc_ifs.sv
  - llc_header_decoder.sv
  - llc_payload_engine.sv
  - llc_completion_builder.sv
  - llc_copy_unit.sv
  - target: test
    files:
      - llc_copy_unit_props.sv
      - tb_llc_copy_unit.sv
